// ==== hdl/axi_lite_pkg.sv ====
package axi_lite_pkg;

    // response codes, only the two the memory can return
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // ar and aw payload
    typedef struct packed {
        logic [31:0] addr;
    } addr_req_t;

    // w payload, full words only
    typedef struct packed {
        logic [31:0] data;
    } wdata_t;

    // r payload
    typedef struct packed {
        logic [31:0] data;
        axi_resp_e   resp;
    } rdata_t;

    // b payload
    typedef struct packed {
        axi_resp_e resp;
    } bresp_t;

endpackage

// ==== hdl/bank_decoder.sv ====
`timescale 1ns/100ps

module bank_decoder import axi_lite_pkg::*, mem_map_pkg::*; #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  addr_req_t            bus_ar,
    input  logic                 bus_ar_valid,
    output logic                 bus_ar_ready,
    input  addr_req_t            bus_aw,
    input  logic                 bus_aw_valid,
    output logic                 bus_aw_ready,
    input  wdata_t               bus_w,
    input  logic                 bus_w_valid,
    output logic                 bus_w_ready,
    output bank_req_t            bank_req,
    output logic [NUM_BANKS-1:0] bank_req_valid,
    input  logic [NUM_BANKS-1:0] bank_req_ready,
    output logic                 err_valid,
    output bank_op_e             err_op,
    input  logic                 err_ready
);

    localparam int          SEL_W     = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
    localparam logic [31:0] MEM_BYTES = 32'(NUM_BANKS * BANK_WORDS * 4);

    logic             rd_req;
    logic             wr_req;      // aw and w must arrive together
    logic [31:0]      offset;      // below base wraps to a large value
    logic [29:0]      word_addr;
    logic [SEL_W-1:0] bank_sel;
    logic             in_range;
    logic             accept;

    assign rd_req    = bus_ar_valid;
    assign wr_req    = !bus_ar_valid && bus_aw_valid && bus_w_valid;
    assign offset    = (rd_req ? bus_ar.addr : bus_aw.addr) - MEM_BASE;
    assign in_range  = offset < MEM_BYTES;
    assign word_addr = offset[31:2];
    assign bank_sel  = SEL_W'(word_addr % NUM_BANKS);

    assign bank_req.op    = rd_req ? OP_READ : OP_WRITE;
    assign bank_req.index = 16'(word_addr / NUM_BANKS);
    assign bank_req.wdata = bus_w.data;

    // out of range requests are taken at once, in range ones wait for the bank
    assign accept = (rd_req || wr_req) && !err_valid &&
                    (!in_range || bank_req_ready[bank_sel]);

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_req_valid[b] = (rd_req || wr_req) && in_range && !err_valid &&
                                (bank_sel == SEL_W'(b));
        end
    end

    assign bus_ar_ready = rd_req && accept;
    assign bus_aw_ready = wr_req && accept;
    assign bus_w_ready  = wr_req && accept;

    // one-entry error slot
    always_ff @(posedge clk) begin
        if (rst) begin
            err_valid <= 1'b0;
        end else if (err_valid && err_ready) begin
            err_valid <= 1'b0;
        end else if (accept && !in_range) begin
            err_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !in_range) err_op <= bank_req.op;
    end

endmodule

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/100ps

module bus_arbiter import axi_lite_pkg::*, mem_map_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // ifu, read only
    input  addr_req_t ifu_ar,
    input  logic      ifu_ar_valid,
    output logic      ifu_ar_ready,
    output rdata_t    ifu_r,
    output logic      ifu_r_valid,
    input  logic      ifu_r_ready,

    // lsu
    input  addr_req_t lsu_ar,
    input  logic      lsu_ar_valid,
    output logic      lsu_ar_ready,
    output rdata_t    lsu_r,
    output logic      lsu_r_valid,
    input  logic      lsu_r_ready,
    input  addr_req_t lsu_aw,
    input  logic      lsu_aw_valid,
    output logic      lsu_aw_ready,
    input  wdata_t    lsu_w,
    input  logic      lsu_w_valid,
    output logic      lsu_w_ready,
    output bresp_t    lsu_b,
    output logic      lsu_b_valid,
    input  logic      lsu_b_ready,

    // shared bus towards the decoder and collector
    output addr_req_t bus_ar,
    output logic      bus_ar_valid,
    input  logic      bus_ar_ready,
    output addr_req_t bus_aw,
    output logic      bus_aw_valid,
    input  logic      bus_aw_ready,
    output wdata_t    bus_w,
    output logic      bus_w_valid,
    input  logic      bus_w_ready,
    input  rdata_t    bus_r,
    input  logic      bus_r_valid,
    output logic      bus_r_ready,
    input  bresp_t    bus_b,
    input  logic      bus_b_valid,
    output logic      bus_b_ready
);

    arb_state_e state;

    logic r_done; // read response handshake on the shared bus
    logic b_done;

    assign r_done = bus_r_valid && bus_r_ready;
    assign b_done = bus_b_valid && bus_b_ready;

    // grant is held until the response handshake, then back to idle
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (ifu_ar_valid) begin
                        state <= ARB_IFU_RD;
                    end else if (lsu_ar_valid) begin
                        state <= ARB_LSU_RD;
                    end else if (lsu_aw_valid || lsu_w_valid) begin
                        state <= ARB_LSU_WR;
                    end
                end
                ARB_IFU_RD, ARB_LSU_RD: if (r_done) state <= ARB_IDLE;
                ARB_LSU_WR:             if (b_done) state <= ARB_IDLE;
                default:                state <= ARB_IDLE;
            endcase
        end
    end

    // payloads, qualified by the valids below
    assign bus_ar = (state == ARB_LSU_RD) ? lsu_ar : ifu_ar;
    assign bus_aw = lsu_aw;
    assign bus_w  = lsu_w;
    assign ifu_r  = bus_r;
    assign lsu_r  = bus_r;
    assign lsu_b  = bus_b;

    always_comb begin
        // nothing connected unless granted
        bus_ar_valid = 1'b0;
        bus_aw_valid = 1'b0;
        bus_w_valid  = 1'b0;
        bus_r_ready  = 1'b0;
        bus_b_ready  = 1'b0;
        ifu_ar_ready = 1'b0;
        ifu_r_valid  = 1'b0;
        lsu_ar_ready = 1'b0;
        lsu_r_valid  = 1'b0;
        lsu_aw_ready = 1'b0;
        lsu_w_ready  = 1'b0;
        lsu_b_valid  = 1'b0;
        case (state)
            ARB_IFU_RD: begin
                bus_ar_valid = ifu_ar_valid;
                ifu_ar_ready = bus_ar_ready;
                ifu_r_valid  = bus_r_valid;
                bus_r_ready  = ifu_r_ready;
            end
            ARB_LSU_RD: begin
                bus_ar_valid = lsu_ar_valid;
                lsu_ar_ready = bus_ar_ready;
                lsu_r_valid  = bus_r_valid;
                bus_r_ready  = lsu_r_ready;
            end
            ARB_LSU_WR: begin
                bus_aw_valid = lsu_aw_valid;
                lsu_aw_ready = bus_aw_ready;
                bus_w_valid  = lsu_w_valid;
                lsu_w_ready  = bus_w_ready;
                lsu_b_valid  = bus_b_valid;
                bus_b_ready  = lsu_b_ready;
            end
            default: ; // idle
        endcase
    end

endmodule

// ==== hdl/mem_map_pkg.sv ====
package mem_map_pkg;

    // first byte of the memory, same as the core's reset vector
    localparam logic [31:0] MEM_BASE = 32'h8000_0000;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bank_op_e;

    // which master owns the shared bus
    typedef enum logic [1:0] {
        ARB_IDLE   = 2'd0,
        ARB_IFU_RD = 2'd1,
        ARB_LSU_RD = 2'd2,
        ARB_LSU_WR = 2'd3
    } arb_state_e;

    typedef struct packed {
        bank_op_e    op;
        logic [15:0] index; // word index inside the bank
        logic [31:0] wdata;
    } bank_req_t;

    typedef struct packed {
        bank_op_e    op;    // echoed so the collector picks r or b
        logic [31:0] rdata;
    } bank_resp_t;

endpackage

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top import axi_lite_pkg::*, mem_map_pkg::*; #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 64
) (
    input  logic clk, rst,
    input  addr_req_t ifu_ar,  input logic ifu_ar_valid, output logic ifu_ar_ready,
    output rdata_t    ifu_r,  output logic ifu_r_valid,  input  logic ifu_r_ready,
    input  addr_req_t lsu_ar,  input logic lsu_ar_valid, output logic lsu_ar_ready,
    output rdata_t    lsu_r,  output logic lsu_r_valid,  input  logic lsu_r_ready,
    input  addr_req_t lsu_aw,  input logic lsu_aw_valid, output logic lsu_aw_ready,
    input  wdata_t    lsu_w,   input logic lsu_w_valid,  output logic lsu_w_ready,
    output bresp_t    lsu_b,  output logic lsu_b_valid,  input  logic lsu_b_ready
);

    // shared bus between arbiter, decoder and collector
    addr_req_t bus_ar, bus_aw;
    wdata_t    bus_w;
    rdata_t    bus_r;
    bresp_t    bus_b;
    logic      bus_ar_valid, bus_ar_ready, bus_aw_valid, bus_aw_ready;
    logic      bus_w_valid, bus_w_ready, bus_r_valid, bus_r_ready;
    logic      bus_b_valid, bus_b_ready;

    bank_req_t                    bank_req;   // broadcast, valid picks the bank
    logic       [NUM_BANKS-1:0]   bank_req_valid, bank_req_ready;
    bank_resp_t [NUM_BANKS-1:0]   bank_resp;
    logic       [NUM_BANKS-1:0]   bank_resp_valid, bank_resp_ready;
    logic                         err_valid, err_ready;
    bank_op_e                     err_op;

    bus_arbiter u_arbiter (.*);

    bank_decoder #(.NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS)) u_decoder (.*);

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sram_bank #(.BANK_WORDS(BANK_WORDS)) u_bank (
            .clk, .rst,
            .req(bank_req), .req_valid(bank_req_valid[b]), .req_ready(bank_req_ready[b]),
            .resp(bank_resp[b]), .resp_valid(bank_resp_valid[b]),
            .resp_ready(bank_resp_ready[b])
        );
    end

    resp_collector #(.NUM_BANKS(NUM_BANKS)) u_collector (.*);

endmodule

// ==== hdl/resp_collector.sv ====
`timescale 1ns/100ps

module resp_collector import axi_lite_pkg::*, mem_map_pkg::*; #(
    parameter int NUM_BANKS = 4
) (
    input  bank_resp_t [NUM_BANKS-1:0] bank_resp,
    input  logic       [NUM_BANKS-1:0] bank_resp_valid,
    output logic       [NUM_BANKS-1:0] bank_resp_ready,
    input  logic                       err_valid,
    input  bank_op_e                   err_op,
    output logic                       err_ready,
    output rdata_t                     bus_r,
    output logic                       bus_r_valid,
    input  logic                       bus_r_ready,
    output bresp_t                     bus_b,
    output logic                       bus_b_valid,
    input  logic                       bus_b_ready
);

    bank_resp_t sel;     // the one valid bank response, if any
    logic       any_bank;

    always_comb begin
        sel      = '0;
        any_bank = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_resp_valid[b]) begin
                sel      = bank_resp[b];
                any_bank = 1'b1;
            end
            bank_resp_ready[b] = (bank_resp[b].op == OP_READ) ? bus_r_ready : bus_b_ready;
        end
    end

    assign err_ready = (err_op == OP_READ) ? bus_r_ready : bus_b_ready;

    assign bus_r_valid = (any_bank && sel.op == OP_READ) || (err_valid && err_op == OP_READ);
    assign bus_b_valid = (any_bank && sel.op == OP_WRITE) || (err_valid && err_op == OP_WRITE);

    // errors carry zero data
    assign bus_r.data = err_valid ? 32'h0 : sel.rdata;
    assign bus_r.resp = err_valid ? RESP_SLVERR : RESP_OKAY;
    assign bus_b.resp = err_valid ? RESP_SLVERR : RESP_OKAY;

endmodule

// ==== hdl/sram_bank.sv ====
`timescale 1ns/100ps

module sram_bank import mem_map_pkg::*; #(
    parameter int BANK_WORDS = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  bank_req_t  req,
    input  logic       req_valid,
    output logic       req_ready,
    output bank_resp_t resp,
    output logic       resp_valid,
    input  logic       resp_ready
);

    localparam int IDX_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

    logic [31:0]      mem [BANK_WORDS];
    logic [IDX_W-1:0] word_sel;
    logic             req_fire;

    assign word_sel  = req.index[IDX_W-1:0]; // decoder keeps index in range
    assign req_ready = !resp_valid;          // one response slot
    assign req_fire  = req_valid && req_ready;

    // write lands on the request edge
    always_ff @(posedge clk) begin
        if (req_fire && req.op == OP_WRITE) begin
            mem[word_sel] <= req.wdata;
        end
    end

    // response payload, held while resp_valid waits
    always_ff @(posedge clk) begin
        if (req_fire) begin
            resp.op    <= req.op;
            resp.rdata <= mem[word_sel];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (req_fire) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0; // accepted or never set
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module mem_subsys_tb \
    --Mdir obj_dir -o mem_subsys_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/mem_subsys_sim > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0

// ==== test/mem_subsys_sva.sv ====
`timescale 1ns/100ps

module mem_subsys_sva import axi_lite_pkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   ifu_ar_ready,
    input rdata_t ifu_r,
    input logic   ifu_r_valid,
    input logic   ifu_r_ready,
    input logic   lsu_ar_ready,
    input rdata_t lsu_r,
    input logic   lsu_r_valid,
    input logic   lsu_r_ready,
    input logic   lsu_aw_ready,
    input logic   lsu_w_ready,
    input bresp_t lsu_b,
    input logic   lsu_b_valid,
    input logic   lsu_b_ready
);

    int fail_count = 0; // failed assertions, read by the testbench

    // stalled responses keep valid and payload
    assert property (@(posedge clk) disable iff (rst)
        ifu_r_valid && !ifu_r_ready |=> ifu_r_valid && $stable(ifu_r))
        else begin
            fail_count++;
            $error("ifu r response changed while stalled");
        end
    assert property (@(posedge clk) disable iff (rst)
        lsu_r_valid && !lsu_r_ready |=> lsu_r_valid && $stable(lsu_r))
        else begin
            fail_count++;
            $error("lsu r response changed while stalled");
        end
    assert property (@(posedge clk) disable iff (rst)
        lsu_b_valid && !lsu_b_ready |=> lsu_b_valid && $stable(lsu_b))
        else begin
            fail_count++;
            $error("lsu b response changed while stalled");
        end

    assert property (@(posedge clk) disable iff (rst) !(ifu_r_valid && lsu_r_valid))
        else begin
            fail_count++;
            $error("both masters see a read response");
        end

    assert property (@(posedge clk) rst |=> !(ifu_ar_ready || ifu_r_valid || lsu_ar_ready ||
        lsu_r_valid || lsu_aw_ready || lsu_w_ready || lsu_b_valid))
        else begin
            fail_count++;
            $error("handshake signal high right after reset");
        end

endmodule

bind mem_subsys_top mem_subsys_sva u_sva (.*);

// ==== test/mem_subsys_tb.sv ====
`timescale 1ns/100ps

module mem_subsys_tb import axi_lite_pkg::*, mem_map_pkg::*;;

    localparam int NUM_BANKS   = 4;
    localparam int BANK_WORDS  = 64;
    localparam int TOTAL_WORDS = NUM_BANKS * BANK_WORDS;
    // 256 writes, 256 reads, 16 shared, 8 contended, 4 bad, 256 rescan, 40 random, 1 latency
    localparam int NUM_TXN     = 837;
    localparam int CYCLE_LIMIT = 40 * NUM_TXN + 100;

    logic clk, rst;
    addr_req_t ifu_ar, lsu_ar, lsu_aw;
    wdata_t    lsu_w;
    rdata_t    ifu_r, lsu_r;
    bresp_t    lsu_b;
    logic      ifu_ar_valid, ifu_ar_ready, ifu_r_valid, ifu_r_ready;
    logic      lsu_ar_valid, lsu_ar_ready, lsu_r_valid, lsu_r_ready;
    logic      lsu_aw_valid, lsu_aw_ready, lsu_w_valid, lsu_w_ready;
    logic      lsu_b_valid, lsu_b_ready;

    logic [31:0] model [logic [31:0]]; // byte address -> word
    rdata_t      ifu_exp[$];
    rdata_t      lsu_r_exp[$];
    bresp_t      lsu_b_exp[$];
    rdata_t      ifu_cur, lsu_cur;
    bresp_t      b_cur;
    int          ifu_r_cnt, lsu_r_cnt, lsu_b_cnt;
    int          errors, cycles, seed, lat_cnt, target_ifu;
    logic        bp_en, lat_armed, lat_seen;
    logic [31:0] rnd;

    mem_subsys_top #(.NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS)) u_mem_subsys_top (.*);

    always #5 clk = ~clk;

    function automatic logic is_mapped(input logic [31:0] addr);
        return addr >= MEM_BASE && addr < MEM_BASE + 32'(TOTAL_WORDS * 4);
    endfunction

    function automatic logic [31:0] word_addr(input int idx);
        return MEM_BASE + 32'(idx * 4);
    endfunction

    function automatic rdata_t expect_read(input logic [31:0] addr);
        rdata_t e;
        e.data = 32'h0;
        e.resp = RESP_SLVERR; // unmapped gives zero data
        if (is_mapped(addr)) begin
            e.data = model.exists(addr) ? model[addr] : 32'h0;
            e.resp = RESP_OKAY;
        end
        return e;
    endfunction

    // all tasks start and end on a falling edge
    task automatic ifu_read(input logic [31:0] addr);
        int target;
        target = ifu_r_cnt + 1;
        ifu_exp.push_back(expect_read(addr));
        ifu_ar.addr  = addr;
        ifu_ar_valid = 1'b1;
        do @(negedge clk); while (!ifu_ar_ready);
        @(negedge clk);
        ifu_ar_valid = 1'b0;
        while (ifu_r_cnt < target) @(negedge clk);
    endtask

    task automatic lsu_read(input logic [31:0] addr);
        int target;
        target = lsu_r_cnt + 1;
        lsu_r_exp.push_back(expect_read(addr));
        lsu_ar.addr  = addr;
        lsu_ar_valid = 1'b1;
        do @(negedge clk); while (!lsu_ar_ready);
        @(negedge clk);
        lsu_ar_valid = 1'b0;
        while (lsu_r_cnt < target) @(negedge clk);
    endtask

    task automatic lsu_write(input logic [31:0] addr, input logic [31:0] data);
        int     target;
        bresp_t e;
        target = lsu_b_cnt + 1;
        e.resp = is_mapped(addr) ? RESP_OKAY : RESP_SLVERR;
        lsu_b_exp.push_back(e);
        if (is_mapped(addr)) model[addr] = data;
        lsu_aw.addr  = addr;
        lsu_w.data   = data;
        lsu_aw_valid = 1'b1;
        lsu_w_valid  = 1'b1;
        do @(negedge clk); while (!lsu_aw_ready); // aw and w accepted together
        assert (lsu_w_ready === 1'b1) else begin
            errors++;
            $display("CHECK FAILED at %0t: lsu_w_ready expected 1 got %b",
                     $time, lsu_w_ready);
        end
        @(negedge clk);
        lsu_aw_valid = 1'b0;
        lsu_w_valid  = 1'b0;
        while (lsu_b_cnt < target) @(negedge clk);
    endtask

    // response readies with random stalls under back-pressure
    always @(negedge clk) begin
        if (bp_en) begin
            ifu_r_ready = ($random(seed) & 3) == 0;
            lsu_r_ready = ($random(seed) & 3) == 0;
            lsu_b_ready = ($random(seed) & 3) == 0;
        end else begin
            ifu_r_ready = 1'b1;
            lsu_r_ready = 1'b1;
            lsu_b_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && ifu_r_valid && ifu_r_ready) begin
            if (ifu_exp.size() == 0) begin
                errors++;
                $display("ifu read response at %0t with no read outstanding", $time);
            end else begin
                ifu_cur = ifu_exp.pop_front();
                assert (ifu_r.data === ifu_cur.data) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: ifu_r.data expected %h got %h",
                             $time, ifu_cur.data, ifu_r.data);
                end
                assert (ifu_r.resp === ifu_cur.resp) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: ifu_r.resp expected %h got %h",
                             $time, ifu_cur.resp, ifu_r.resp);
                end
            end
            ifu_r_cnt++;
        end
    end

    always @(posedge clk) begin
        if (!rst && lsu_r_valid && lsu_r_ready) begin
            if (lsu_r_exp.size() == 0) begin
                errors++;
                $display("lsu read response at %0t with no read outstanding", $time);
            end else begin
                lsu_cur = lsu_r_exp.pop_front();
                assert (lsu_r.data === lsu_cur.data) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: lsu_r.data expected %h got %h",
                             $time, lsu_cur.data, lsu_r.data);
                end
                assert (lsu_r.resp === lsu_cur.resp) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: lsu_r.resp expected %h got %h",
                             $time, lsu_cur.resp, lsu_r.resp);
                end
            end
            lsu_r_cnt++;
        end
    end

    always @(posedge clk) begin
        if (!rst && lsu_b_valid && lsu_b_ready) begin
            if (lsu_b_exp.size() == 0) begin
                errors++;
                $display("lsu write response at %0t with no write outstanding", $time);
            end else begin
                b_cur = lsu_b_exp.pop_front();
                assert (lsu_b.resp === b_cur.resp) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: lsu_b.resp expected %h got %h",
                             $time, b_cur.resp, lsu_b.resp);
                end
            end
            lsu_b_cnt++;
        end
    end

    // edges from arvalid raised in idle to the edge that sees rvalid
    always @(posedge clk) begin
        if (lat_armed) begin
            lat_cnt++;
            if (ifu_r_valid && !lat_seen) begin
                lat_seen = 1'b1;
                assert (lat_cnt == 3) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: ifu_r_valid latency expected 3 got %0d",
                             $time, lat_cnt);
                end
            end
        end else begin
            lat_cnt  = 0;
            lat_seen = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            errors++;
            errors += u_mem_subsys_top.u_sva.fail_count;
            $display("timeout after %0d cycles, a transaction never completed", cycles);
            $display("errors: %0d", errors);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        clk          = 0;
        rst          = 1;
        seed         = 87634;
        errors       = 0;
        cycles       = 0;
        lat_cnt      = 0;
        lat_armed    = 0;
        lat_seen     = 0;
        bp_en        = 0;
        ifu_r_cnt    = 0;
        lsu_r_cnt    = 0;
        lsu_b_cnt    = 0;
        ifu_ar       = '0;
        lsu_ar       = '0;
        lsu_aw       = '0;
        lsu_w        = '0;
        ifu_ar_valid = 0;
        lsu_ar_valid = 0;
        lsu_aw_valid = 0;
        lsu_w_valid  = 0;
        ifu_r_ready  = 1;
        lsu_r_ready  = 1;
        lsu_b_ready  = 1;
        repeat (4) @(negedge clk);
        rst = 0;

        // fill every word in every bank and read it back from the lsu
        for (int i = 0; i < TOTAL_WORDS; i++) begin
            rnd = $random(seed);
            lsu_write(word_addr(i), rnd);
        end
        for (int i = 0; i < TOTAL_WORDS; i++) lsu_read(word_addr(i));

        // ifu sees lsu data
        for (int i = 0; i < 16; i++) ifu_read(word_addr((i * 13) % TOTAL_WORDS));

        // same-cycle requests where the ifu wins
        for (int i = 0; i < 4; i++) begin
            target_ifu = ifu_r_cnt + 1;
            fork
                ifu_read(word_addr(i * 7));
                begin
                    lsu_read(word_addr(i * 7 + 1));
                    assert (ifu_r_cnt == target_ifu) else begin
                        errors++;
                        $display("lsu read finished before the ifu read at %0t", $time);
                    end
                end
            join
        end

        // unmapped accesses
        lsu_read(MEM_BASE - 32'd4);
        ifu_read(MEM_BASE + 32'(TOTAL_WORDS * 4));
        lsu_write(MEM_BASE - 32'd4, 32'hdead_beef);
        lsu_write(MEM_BASE + 32'(TOTAL_WORDS * 4), 32'hcafe_f00d);
        for (int i = 0; i < TOTAL_WORDS; i++) ifu_read(word_addr(i));

        // random mix under response stalls
        bp_en = 1;
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            case (rnd[1:0])
                2'd0:    ifu_read(word_addr(int'(rnd[15:8])));
                2'd1:    lsu_read(word_addr(int'(rnd[15:8])));
                default: lsu_write(word_addr(int'(rnd[15:8])), $random(seed));
            endcase
        end
        bp_en = 0;
        repeat (2) @(negedge clk);

        lat_armed = 1;
        ifu_read(word_addr(5));
        lat_armed = 0;
        repeat (4) @(negedge clk);

        errors += u_mem_subsys_top.u_sva.fail_count;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/axi_lite_pkg.sv
hdl/mem_map_pkg.sv
hdl/bus_arbiter.sv
hdl/bank_decoder.sv
hdl/sram_bank.sv
hdl/resp_collector.sv
hdl/mem_subsys_top.sv
test/mem_subsys_sva.sv
test/mem_subsys_tb.sv
